//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_two_stage_core
SEED      ?= 1
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f filelist.f
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_two_stage_core.sv
`default_nettype none

module tb_two_stage_core;

  timeunit 1ns;
  timeprecision 100ps;

  logic        CLK;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        dmem_ren;
  logic        dmem_wen;
  logic [3:0]  dmem_byte_en;
  logic        misaligned;
  logic        halt;

  // 1 KiB each and word addressed
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  // reference model state
  logic [31:0] mmem [256];
  logic [31:0] mreg [32];
  logic [31:0] prog [$];
  int          mis_exp;
  int          mis_seen;
  int          reads_exp;
  int          reads_seen;
  int          halt_strobes;
  int          errors;
  int          failed;
  time         deadline = 2000;
  string       names [5] = '{"alu", "load_store", "control", "misaligned", "halt"};

  two_stage_core #(.RESET_PC(32'h0000_0000)) UUT (
    .CLK(CLK), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_byte_en(dmem_byte_en),
    .misaligned(misaligned), .halt(halt)
  );

  bind two_stage_core two_stage_core_assertions sva (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // combinational memory reads
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge CLK) begin : dmem_write
    int b;
    if (!rst && dmem_wen) begin
      for (b = 0; b < 4; b++) begin
        if (dmem_byte_en[b]) dmem[dmem_addr[9:2]][b*8 +: 8] = dmem_wdata[b*8 +: 8];
      end
    end
  end

  always @(posedge CLK) begin
    if (rst) begin
      mis_seen = 0;
      reads_seen = 0;
      halt_strobes = 0;
    end else begin
      if (misaligned) mis_seen++;
      if (dmem_ren) reads_seen++;
      if (halt && (dmem_ren || dmem_wen)) halt_strobes++;
    end
  end

  // instruction encoders
  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                        input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                        input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, input int rd, input int op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // depends on every address bit
  function automatic logic [31:0] fill_word(input int idx);
    return (idx * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic misal(input logic [2:0] f3, input logic [31:0] addr);
    return (f3[1:0] == 2'd2) ? (addr[1:0] != 2'd0) : (f3[1:0] == 2'd1) ? addr[0] : 1'b0;
  endfunction

  function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] w,
                                           input logic [1:0] off);
    logic [7:0]  by;
    logic [15:0] hw;
    by = w[off*8 +: 8];
    hw = w[off[1]*16 +: 16];
    case (f3)
      3'd0:    return {{24{by[7]}}, by};
      3'd1:    return {{16{hw[15]}}, hw};
      3'd4:    return {24'd0, by};
      3'd5:    return {16'd0, hw};
      default: return w;
    endcase
  endfunction

  // instruction-set model that runs the program in imem until ecall
  function automatic void run_model();
    logic [31:0] pc, npc, ins, a, b, r, immi, imms, immb, addr;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    pc = 0;
    for (steps = 0; steps < 4000; steps++) begin
      ins  = imem[pc[9:2]];
      f3   = ins[14:12];
      a    = mreg[ins[19:15]];
      b    = mreg[ins[24:20]];
      immi = {{20{ins[31]}}, ins[31:20]};
      imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      wr   = 1'b1;
      r    = 32'd0;
      npc  = pc + 32'd4;
      case (ins[6:0])
        7'h37: r = {ins[31:12], 12'h000};
        7'h17: r = pc + {ins[31:12], 12'h000};
        7'h6f: begin
          r = pc + 32'd4;
          npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h67: begin
          r = pc + 32'd4;
          npc = (a + immi) & ~32'd1;
        end
        7'h63: begin
          wr = 1'b0;
          case (f3)
            3'd0: if (a == b) npc = pc + immb;
            3'd1: if (a != b) npc = pc + immb;
            3'd4: if ($signed(a) < $signed(b)) npc = pc + immb;
            3'd5: if ($signed(a) >= $signed(b)) npc = pc + immb;
            3'd6: if (a < b) npc = pc + immb;
            3'd7: if (a >= b) npc = pc + immb;
            default: ;
          endcase
        end
        7'h03: begin
          addr = a + immi;
          if (misal(f3, addr)) begin
            mis_exp++;
            wr = 1'b0;
          end else begin
            reads_exp++;
            r = load_ref(f3, mmem[addr[9:2]], addr[1:0]);
          end
        end
        7'h23: begin
          wr = 1'b0;
          addr = a + imms;
          if (misal(f3, addr)) mis_exp++;
          else if (f3[1:0] == 2'd0) mmem[addr[9:2]][addr[1:0]*8 +: 8] = b[7:0];
          else if (f3[1:0] == 2'd1) mmem[addr[9:2]][addr[1]*16 +: 16] = b[15:0];
          else mmem[addr[9:2]] = b;
        end
        7'h13: r = alu_ref(f3, ins[30] && f3 == 3'd5, a, immi);
        7'h33: r = alu_ref(f3, ins[30], a, b);
        7'h73: if (ins[31:7] == 25'd0) return;
        default: wr = 1'b0;
      endcase
      if (ins[6:0] == 7'h73) wr = 1'b0;
      if (wr && ins[11:7] != 5'd0) mreg[ins[11:7]] = r;
      pc = npc;
    end
  endfunction

  function automatic void gen_alu();
    int k, f3, imm;
    k = $urandom % 8;
    f3 = $urandom % 8;
    imm = $urandom % 4096;
    if (k == 0) prog.push_back(enc_u($urandom, $urandom % 16, 7'h37));
    else if (k == 1) prog.push_back(enc_u($urandom, $urandom % 16, 7'h17));
    else if (k < 5) begin
      // shift immediates carry shamt plus bit 30 for sra
      if (f3 == 1) imm = imm % 32;
      else if (f3 == 5) imm = (imm % 32) | (($urandom % 2) * 1024);
      prog.push_back(enc_i(imm, $urandom % 16, f3, $urandom % 16, 7'h13));
    end else begin
      prog.push_back(enc_r(((f3 == 0 || f3 == 5) && ($urandom % 2)) ? 32 : 0,
                           $urandom % 16, $urandom % 16, f3, $urandom % 16));
    end
  endfunction

  // x0 based accesses in the scratch area where loose allows any offset
  function automatic void gen_mem(input logic loose);
    int w, off, f3;
    w = $urandom % 3;
    off = 'h200 + $urandom % 256;
    if (!loose) off = off & ~((1 << w) - 1);
    if ($urandom % 2) prog.push_back(enc_s(off, 1 + $urandom % 15, 0, w));
    else begin
      f3 = w;
      if (w < 2 && ($urandom % 2)) f3 = w + 4;
      prog.push_back(enc_i(off, 0, f3, $urandom % 16, 7'h03));
    end
  endfunction

  // forward transfer over k filler words that must not run when taken
  function automatic void gen_ctrl();
    int kind, k, i, f3, rs1, rt;
    kind = $urandom % 3;
    k = 1 + $urandom % 3;
    if (kind == 0) begin
      f3 = $urandom % 6;
      if (f3 >= 2) f3 = f3 + 2;
      rs1 = 1 + $urandom % 15;
      prog.push_back(enc_b((k + 1) * 4, ($urandom % 4 == 0) ? rs1 : 1 + $urandom % 15,
                           rs1, f3));
    end else if (kind == 1) begin
      prog.push_back(enc_j((k + 1) * 4, $urandom % 16));
    end else begin
      rt = 1 + $urandom % 15;
      prog.push_back(enc_i((prog.size() + 2 + k) * 4, 0, 0, rt, 7'h13));
      // odd offset whose bit 0 is dropped from the target
      prog.push_back(enc_i(1, rt, 0, $urandom % 16, 7'h67));
    end
    for (i = 0; i < k; i++) begin
      if ($urandom % 3 == 0) gen_mem(1'b0);
      else gen_alu();
    end
  endfunction

  function automatic void build_program(input int mode);
    int i;
    prog.delete();
    for (i = 1; i < 16; i++) begin
      prog.push_back(enc_u($urandom, i, 7'h37));
      prog.push_back(enc_i($urandom % 4096, i, 0, i, 7'h13));
    end
    for (i = 0; i < ((mode == 2) ? 40 : 80); i++) begin
      case (mode)
        0: gen_alu();
        1: gen_mem(1'b0);
        2: gen_ctrl();
        3: if ($urandom % 2) gen_mem(1'b1); else gen_alu();
        default: if ($urandom % 2) gen_mem(1'b0); else gen_alu();
      endcase
    end
    // result area stores then ecall
    for (i = 1; i < 16; i++) prog.push_back(enc_s('h300 + 4 * (i - 1), i, 0, 2));
    prog.push_back(32'h0000_0073);
    for (i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
      dmem[i] = fill_word(i);
      mmem[i] = fill_word(i);
    end
    for (i = 0; i < 32; i++) mreg[i] = 32'd0;
    mis_exp = 0;
    reads_exp = 0;
    run_model();
  endfunction

  task automatic apply_reset();
    @(posedge CLK);
    #2 rst = 1'b1;
    repeat (4) @(posedge CLK);
    #2 rst = 1'b0;
  endtask

  task automatic run_test(input int t);
    int          i, errs;
    logic [31:0] held_addr;
    errs = 0;
    build_program(t);
    apply_reset();
    assert (imem_addr === 32'h0) else begin
      $display("Fail %0t imem_addr got %08h expected %08h", $time, imem_addr, 32'h0);
      errs++;
    end
    deadline = $time + (prog.size() * 4 + 64) * 20;
    do begin
      @(posedge CLK);
      #2;
    end while (!halt);
    held_addr = imem_addr;
    repeat (6) @(posedge CLK);
    #2;
    assert (halt === 1'b1) else begin
      $display("Fail %0t halt got %b expected 1", $time, halt);
      errs++;
    end
    assert (imem_addr === held_addr) else begin
      $display("Fail %0t imem_addr got %08h expected %08h", $time, imem_addr, held_addr);
      errs++;
    end
    assert (halt_strobes == 0) else begin
      $display("data strobes seen while halted at %0t", $time);
      errs++;
    end
    assert (mis_seen == mis_exp) else begin
      $display("Fail %0t misaligned count got %0d expected %0d", $time, mis_seen, mis_exp);
      errs++;
    end
    assert (reads_seen == reads_exp) else begin
      $display("Fail %0t dmem_ren count got %0d expected %0d", $time, reads_seen, reads_exp);
      errs++;
    end
    for (i = 0; i < 256; i++) begin
      assert (dmem[i] === mmem[i]) else begin
        $display("Fail %0t dmem[%03h] got %08h expected %08h", $time, i * 4, dmem[i], mmem[i]);
        errs++;
      end
    end
    $display("test %0d %s: %0d instructions, %0d errors", t, names[t], prog.size(), errs);
    errors += errs;
    if (errs != 0) failed++;
  endtask

  initial begin
    while ($time <= deadline) @(posedge CLK);
    $display("timeout: the core did not reach ecall within the cycle budget");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst = 1'b1;
    errors = 0;
    failed = 0;
    void'($urandom(32'ha770));
    for (int t = 0; t < 5; t++) run_test(t);
    $display("5 tests, %0d failed, %0d errors", failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/two_stage_core_assertions.sv
`default_nettype none

module two_stage_core_assertions (
  input logic CLK,
  input logic rst,
  input logic dmem_ren,
  input logic dmem_wen,
  input logic misaligned,
  input logic redirect,
  input logic halt
);

  timeunit 1ns;
  timeprecision 100ps;

  // one direction per cycle on the data bus
  read_write_exclusive: assert property (@(posedge CLK) disable iff (rst)
    !(dmem_ren && dmem_wen))
    else $error("dmem_ren and dmem_wen high together");

  // a faulting access never reaches the bus
  no_strobe_when_misaligned: assert property (@(posedge CLK) disable iff (rst)
    misaligned |-> !(dmem_ren || dmem_wen))
    else $error("data strobe during misaligned access");

  // slot behind a taken transfer is a bubble
  no_strobe_after_redirect: assert property (@(posedge CLK) disable iff (rst)
    redirect |=> !(dmem_ren || dmem_wen))
    else $error("data strobe from flushed slot");

  no_strobe_while_halted: assert property (@(posedge CLK) disable iff (rst)
    halt |-> !(dmem_ren || dmem_wen))
    else $error("data strobe while halted");

endmodule

`default_nettype wire

//--- filelist.f
verilog/rv32i_types_pkg.sv
verilog/dbus_pkg.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/rv32i_reg_file.sv
verilog/dmem_lane.sv
verilog/fetch_stage.sv
verilog/fetch_execute_reg.sv
verilog/execute_stage.sv
verilog/two_stage_core.sv
bench/two_stage_core_assertions.sv
bench/tb_two_stage_core.sv

//--- verilog/alu.sv
`default_nettype none

module alu import rv32i_types_pkg::*; (
  input  alu_op_t aluop,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = port_b[4:0];

  always_comb begin
    case (aluop)
      ALU_ADD:  port_out = port_a + port_b;
      ALU_SUB:  port_out = port_a - port_b;
      ALU_SLL:  port_out = port_a << shamt;
      ALU_SLT:  port_out = {31'd0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: port_out = {31'd0, port_a < port_b};
      ALU_XOR:  port_out = port_a ^ port_b;
      ALU_SRL:  port_out = port_a >> shamt;
      ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
      ALU_OR:   port_out = port_a | port_b;
      ALU_AND:  port_out = port_a & port_b;
      default:  port_out = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
`default_nettype none

module control_unit import rv32i_types_pkg::*, dbus_pkg::*; (
  input  word_t        instr,
  output alu_op_t      alu_op,
  output logic         alu_a_sel,
  output logic         alu_b_sel,
  output w_sel_t       w_sel,
  output logic         wen,
  output logic         dren,
  output logic         dwen,
  output logic         branch,
  output logic         jal,
  output logic         jalr,
  output logic         halt,
  output branch_type_t branch_type,
  output load_type_t   load_type,
  output reg_idx_t     rs1,
  output reg_idx_t     rs2,
  output reg_idx_t     rd,
  output word_t        imm_u
);

  opcode_t    opcode;
  logic [2:0] funct3;
  alu_op_t    arith_op;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  // fixed field positions across all formats
  assign rs1   = instr[19:15];
  assign rs2   = instr[24:20];
  assign rd    = instr[11:7];
  assign imm_u = {instr[31:12], 12'h000};

  // funct3 doubles as branch kind and access width
  assign branch_type = branch_type_t'(funct3);
  assign load_type   = load_type_t'(funct3);

  // instr[30] picks sub and sra, sub only exists in the register form
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (instr[30] && opcode == OP) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    // defaults decode to a no-op
    alu_op    = ALU_ADD;
    alu_a_sel = 1'b0;
    alu_b_sel = 1'b0;
    w_sel     = W_ALU;
    wen       = 1'b0;
    dren      = 1'b0;
    dwen      = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    jalr      = 1'b0;
    halt      = 1'b0;
    case (opcode)
      LUI: begin
        wen   = 1'b1;
        w_sel = W_IMM_U;
      end
      AUIPC: begin
        wen       = 1'b1;
        alu_a_sel = 1'b1;
        alu_b_sel = 1'b1;
      end
      JAL: begin
        wen   = 1'b1;
        w_sel = W_PC4;
        jal   = 1'b1;
      end
      JALR: begin
        wen   = 1'b1;
        w_sel = W_PC4;
        jalr  = 1'b1;
      end
      BRANCH: branch = 1'b1;
      LOAD: begin
        wen       = 1'b1;
        dren      = 1'b1;
        alu_b_sel = 1'b1;
        w_sel     = W_LOAD;
      end
      STORE: begin
        dwen      = 1'b1;
        alu_b_sel = 1'b1;
      end
      OP_IMM: begin
        wen       = 1'b1;
        alu_b_sel = 1'b1;
        alu_op    = arith_op;
      end
      OP: begin
        wen    = 1'b1;
        alu_op = arith_op;
      end
      // only ecall is recognised, everything else in this space is ignored
      SYSTEM: halt = (instr[31:7] == 25'd0);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

  // one bit per byte lane, lane 0 is the low byte
  typedef logic [3:0] byte_en_t;

  // low two address bits
  typedef logic [1:0] byte_off_t;

  // funct3 of loads, stores reuse the same codes
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_type_t;

endpackage

`default_nettype wire

//--- verilog/dmem_lane.sv
`default_nettype none

module dmem_lane import rv32i_types_pkg::*, dbus_pkg::*; (
  input  load_type_t load_type,
  input  byte_off_t  byte_off,
  input  word_t      store_data,
  input  word_t      dmem_in,
  output byte_en_t   byte_en,
  output word_t      wdata,
  output word_t      ext_out
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // little-endian, lane n holds address offset n
  always_comb begin
    case (load_type)
      LB, LBU: byte_en = byte_en_t'(4'b0001 << byte_off);
      // odd halfword offsets are misaligned and get no lanes
      LH, LHU: byte_en = byte_off[0] ? 4'b0000 :
                         byte_off[1] ? 4'b1100 : 4'b0011;
      LW:      byte_en = 4'b1111;
      default: byte_en = 4'b0000;
    endcase
  end

  // store data copied to every lane, byte_en picks the one that lands
  always_comb begin
    case (load_type)
      LB, LBU: wdata = {4{store_data[7:0]}};
      LH, LHU: wdata = {2{store_data[15:0]}};
      default: wdata = store_data;
    endcase
  end

  // pull the addressed lane out of the read word
  assign lane_byte = dmem_in[{byte_off, 3'b000} +: 8];
  assign lane_half = dmem_in[{byte_off[1], 4'b0000} +: 16];

  always_comb begin
    case (load_type)
      LB:      ext_out = {{24{lane_byte[7]}}, lane_byte};
      LBU:     ext_out = {24'd0, lane_byte};
      LH:      ext_out = {{16{lane_half[15]}}, lane_half};
      LHU:     ext_out = {16'd0, lane_half};
      default: ext_out = dmem_in;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage import rv32i_types_pkg::*, dbus_pkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  word_t    fe_instr,
  input  word_t    fe_pc,
  input  word_t    fe_pc4,
  input  logic     fe_valid,
  output logic     redirect,
  output word_t    redirect_addr,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  input  word_t    dmem_rdata,
  output logic     dmem_ren,
  output logic     dmem_wen,
  output byte_en_t dmem_byte_en,
  output logic     misaligned,
  output logic     halt
);

  alu_op_t      alu_op;
  logic         alu_a_sel;
  logic         alu_b_sel;
  w_sel_t       w_sel;
  logic         cu_wen;
  logic         dren;
  logic         dwen;
  logic         branch;
  logic         jal;
  logic         jalr;
  logic         cu_halt;
  branch_type_t branch_type;
  load_type_t   load_type;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  word_t        imm_u;
  word_t        imm_i;
  word_t        imm_s;
  word_t        imm_b;
  word_t        imm_j;
  word_t        rs1_data;
  word_t        rs2_data;
  word_t        w_data;
  logic         rf_wen;
  word_t        port_a;
  word_t        port_b;
  word_t        alu_out;
  word_t        load_ext;
  byte_off_t    byte_off;
  logic         mal_addr;
  logic         taken;

  control_unit cu (
    .instr(fe_instr), .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
    .w_sel(w_sel), .wen(cu_wen), .dren(dren), .dwen(dwen), .branch(branch),
    .jal(jal), .jalr(jalr), .halt(cu_halt), .branch_type(branch_type),
    .load_type(load_type), .rs1(rs1), .rs2(rs2), .rd(rd), .imm_u(imm_u)
  );

  rv32i_reg_file rf (
    .CLK(CLK), .rst(rst), .wen(rf_wen), .rs1(rs1), .rs2(rs2), .rd(rd),
    .w_data(w_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu alu_i (.aluop(alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

  dmem_lane lane (
    .load_type(load_type), .byte_off(byte_off), .store_data(rs2_data),
    .dmem_in(dmem_rdata), .byte_en(dmem_byte_en), .wdata(dmem_wdata), .ext_out(load_ext)
  );

  // sign extended immediates straight from the instruction bits
  assign imm_i = {{20{fe_instr[31]}}, fe_instr[31:20]};
  assign imm_s = {{20{fe_instr[31]}}, fe_instr[31:25], fe_instr[11:7]};
  assign imm_b = {{19{fe_instr[31]}}, fe_instr[31], fe_instr[7], fe_instr[30:25],
                  fe_instr[11:8], 1'b0};
  assign imm_j = {{11{fe_instr[31]}}, fe_instr[31], fe_instr[19:12], fe_instr[20],
                  fe_instr[30:21], 1'b0};

  // pc as operand a only for auipc, which then also wants the upper immediate
  assign port_a = alu_a_sel ? fe_pc : rs1_data;
  assign port_b = !alu_b_sel ? rs2_data :
                  alu_a_sel  ? imm_u    :
                  dwen       ? imm_s    : imm_i;

  // branch condition
  always_comb begin
    case (branch_type)
      BEQ:     taken = (rs1_data == rs2_data);
      BNE:     taken = (rs1_data != rs2_data);
      BLT:     taken = ($signed(rs1_data) < $signed(rs2_data));
      BGE:     taken = ($signed(rs1_data) >= $signed(rs2_data));
      BLTU:    taken = (rs1_data < rs2_data);
      BGEU:    taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // fetch predicts not-taken, so every taken transfer is a redirect
  assign redirect = fe_valid & (jal | jalr | (branch & taken));
  assign redirect_addr = jalr ? ((rs1_data + imm_i) & ~32'd1) :
                         jal  ? (fe_pc + imm_j)              : (fe_pc + imm_b);

  // data bus address comes out of the alu adder
  assign dmem_addr = alu_out;
  assign byte_off  = alu_out[1:0];

  always_comb begin
    case (load_type)
      LW:      mal_addr = (byte_off != 2'b00);
      LH, LHU: mal_addr = byte_off[0];
      default: mal_addr = 1'b0;
    endcase
  end

  assign misaligned = fe_valid & (dren | dwen) & mal_addr;
  assign dmem_ren   = fe_valid & dren & ~mal_addr;
  assign dmem_wen   = fe_valid & dwen & ~mal_addr;
  assign halt       = fe_valid & cu_halt;

  // write-back source
  always_comb begin
    case (w_sel)
      W_LOAD:  w_data = load_ext;
      W_PC4:   w_data = fe_pc4;
      W_IMM_U: w_data = imm_u;
      default: w_data = alu_out;
    endcase
  end

  // a faulting load leaves rd untouched
  assign rf_wen = fe_valid & cu_wen & ~misaligned;

endmodule

`default_nettype wire

//--- verilog/fetch_execute_reg.sv
`default_nettype none

module fetch_execute_reg import rv32i_types_pkg::*; (
  input  logic  CLK,
  input  logic  rst,
  input  logic  redirect,
  input  logic  halt,
  input  word_t instr_in,
  input  word_t pc_in,
  input  word_t pc4_in,
  output word_t fe_instr,
  output word_t fe_pc,
  output word_t fe_pc4,
  output logic  fe_valid
);

  // payload follows fetch every cycle, the valid bit decides if it counts
  always_ff @(posedge CLK) begin
    if (!halt) begin
      fe_instr <= instr_in;
      fe_pc    <= pc_in;
      fe_pc4   <= pc4_in;
    end
  end

  // a redirect kills whatever fetch produced alongside the taken transfer
  always_ff @(posedge CLK) begin
    if (rst) begin
      fe_valid <= 1'b0;
    end else if (!halt) begin
      fe_valid <= ~redirect;
    end
  end
  // while halted the ecall stays in the slot with valid set

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage import rv32i_types_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  CLK,
  input  logic  rst,
  input  logic  redirect,
  input  logic  halt,
  input  word_t redirect_addr,
  output word_t imem_addr,
  output word_t pc,
  output word_t pc4
);

  // sequential successor, also carried down the pipe as the link value
  assign pc4 = pc + 32'd4;
  assign imem_addr = pc;

  // not-taken prediction, so fetch just walks forward until execute redirects
  always_ff @(posedge CLK) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (halt) begin
      // frozen on ecall
      pc <= pc;
    end else if (redirect) begin
      pc <= redirect_addr;
    end else begin
      pc <= pc4;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rv32i_reg_file.sv
`default_nettype none

module rv32i_reg_file import rv32i_types_pkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  logic     wen,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    w_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [32];

  // x0 is cleared by reset and never written, so it reads as zero
  always_ff @(posedge CLK) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= w_data;
    end
  end

  // asynchronous reads, a write shows up for the next instruction
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv32i_types_pkg.sv
`default_nettype none

package rv32i_types_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // register file index
  typedef logic [4:0] reg_idx_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // funct3 of the conditional branches
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_t;

  // write-back source
  typedef enum logic [1:0] {
    W_LOAD  = 2'd0,
    W_PC4   = 2'd1,
    W_IMM_U = 2'd2,
    W_ALU   = 2'd3
  } w_sel_t;

endpackage

`default_nettype wire

//--- verilog/two_stage_core.sv
`default_nettype none

module two_stage_core import rv32i_types_pkg::*, dbus_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic     CLK,
  input  logic     rst,
  output word_t    imem_addr,
  input  word_t    imem_rdata,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  input  word_t    dmem_rdata,
  output logic     dmem_ren,
  output logic     dmem_wen,
  output byte_en_t dmem_byte_en,
  output logic     misaligned,
  output logic     halt
);

  word_t pc;
  word_t pc4;
  word_t fe_instr;
  word_t fe_pc;
  word_t fe_pc4;
  logic  fe_valid;
  logic  redirect;
  word_t redirect_addr;

  fetch_stage #(.RESET_PC(RESET_PC)) fetch (
    .CLK(CLK), .rst(rst), .redirect(redirect), .halt(halt),
    .redirect_addr(redirect_addr), .imem_addr(imem_addr), .pc(pc), .pc4(pc4)
  );

  // instruction word arrives from imem in the same cycle as its address
  fetch_execute_reg fe_reg (
    .CLK(CLK), .rst(rst), .redirect(redirect), .halt(halt),
    .instr_in(imem_rdata), .pc_in(pc), .pc4_in(pc4),
    .fe_instr(fe_instr), .fe_pc(fe_pc), .fe_pc4(fe_pc4), .fe_valid(fe_valid)
  );

  execute_stage execute (
    .CLK(CLK), .rst(rst), .fe_instr(fe_instr), .fe_pc(fe_pc), .fe_pc4(fe_pc4),
    .fe_valid(fe_valid), .redirect(redirect), .redirect_addr(redirect_addr),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_byte_en(dmem_byte_en),
    .misaligned(misaligned), .halt(halt)
  );

endmodule

`default_nettype wire
